/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcb_mem_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -qF 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
rtl/tcb_lite_pkg.sv
rtl/mem_pkg.sv
rtl/tcb_lite_if.sv
rtl/sram_bank.sv
rtl/tcb_lite_lib_logsize2byteena.sv
rtl/tcb_lite_lib_misaligned_memory_controller.sv
rtl/tcb_mem_top.sv
tests/tcb_mem_checker.sv
tests/tcb_mem_tb.sv

/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////
    // lane payload
    ////////////////////////////////////////////////////////////

    // one byte lane, also the width of each SRAM bank
    typedef logic [7:0] byte_t;

    ////////////////////////////////////////////////////////////
    // geometry defaults
    ////////////////////////////////////////////////////////////

    // byte address width, 256 bytes total
    localparam int unsigned MEM_ADR_W_DEF = 8;

    // bus data width, four lanes
    localparam int unsigned BUS_DAT_W_DEF = 32;

endpackage : mem_pkg

`default_nettype wire

/* rtl/sram_bank.sv */
`default_nettype none
`timescale 1ns/10ps

module sram_bank
    import mem_pkg::*;
#(
    parameter int unsigned DEPTH_LOG = MEM_ADR_W_DEF - $clog2(BUS_DAT_W_DEF/8)
)(
    input  logic                 clk,
    input  logic                 cen,
    input  logic                 wen,
    input  logic [DEPTH_LOG-1:0] adr,
    input  byte_t                wdt,
    output byte_t                rdt
);

    // storage array, one byte per word address
    byte_t mem [0:2**DEPTH_LOG-1];

    // single port, write or read per cycle
    // read data stays put until the next enabled read
    always_ff @(posedge clk) begin
        if (cen) begin
            if (wen) begin
                mem[adr] <= wdt;
            end else begin
                rdt <= mem[adr];
            end
        end
    end

endmodule : sram_bank

`default_nettype wire

/* rtl/tcb_lite_if.sv */
`default_nettype none
`timescale 1ns/10ps

interface tcb_lite_if
    import tcb_lite_pkg::*, mem_pkg::*;
#(
    parameter int unsigned ADR_W = MEM_ADR_W_DEF,
    parameter int unsigned DAT_W = BUS_DAT_W_DEF
)(
    input logic clk,
    input logic arst_n
);

    localparam int unsigned BYT = DAT_W/8;

    // handshake
    logic             vld;
    logic             rdy;
    // request
    logic             wen;
    logic [ADR_W-1:0] adr;
    tcb_siz_t         siz;
    logic [BYT-1:0]   byt;
    logic [DAT_W-1:0] wdt;
    // response
    logic [DAT_W-1:0] rdt;
    tcb_sts_t         sts;

    ////////////////////////////////////////////////////////////
    // request delay for the response phase
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic             vld;
        logic             wen;
        logic [ADR_W-1:0] adr;
        tcb_siz_t         siz;
    } req_t;

    // vld here means an actual transfer, not just a request
    req_t req;
    req_t dly [1:TCB_DLY];

    assign req = '{vld: vld & rdy, wen: wen, adr: adr, siz: siz};

    // shift register, stage 1 holds last cycle's transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i <= TCB_DLY; i++) begin
                dly[i] <= '0;
            end
        end else begin
            dly[1] <= req;
            for (int i = 2; i <= TCB_DLY; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    modport man (
        output vld, wen, adr, siz, byt, wdt,
        input  rdy, rdt, sts, dly
    );

    modport sub (
        input  vld, wen, adr, siz, byt, wdt, dly,
        output rdy, rdt, sts
    );

endinterface : tcb_lite_if

`default_nettype wire

/* rtl/tcb_lite_lib_logsize2byteena.sv */
`default_nettype none
`timescale 1ns/10ps

module tcb_lite_lib_logsize2byteena
    import tcb_lite_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned ADR_W = MEM_ADR_W_DEF,
    parameter int unsigned DAT_W = BUS_DAT_W_DEF
)(
    tcb_lite_if.sub bus_log,
    tcb_lite_if.man bus_byt
);

    localparam int unsigned BYT   = DAT_W/8;
    localparam int unsigned OFF_W = $clog2(BYT);

    // request side and delayed response side address
    logic [ADR_W-1:0] req_adr;
    logic [ADR_W-1:0] rsp_adr;
    // lane offsets
    logic [OFF_W-1:0] req_off;
    logic [OFF_W-1:0] rsp_off;
    // unrotated size masks
    logic [BYT-1:0]   req_msk;
    logic [BYT-1:0]   rsp_msk;
    logic [BYT-1:0]   req_byt;
    // data as byte lanes
    byte_t [BYT-1:0]  log_wdt;
    byte_t [BYT-1:0]  byt_wdt;
    byte_t [BYT-1:0]  byt_rdt;
    byte_t [BYT-1:0]  log_rdt;

    // 2^siz low lanes set
    // sizes beyond the bus width just enable every lane
    function automatic logic [BYT-1:0] size_mask(input tcb_siz_t siz);
        logic [BYT-1:0] msk;
        for (int unsigned i = 0; i < BYT; i++) begin
            msk[i] = (i < (32'd1 << siz));
        end
        return msk;
    endfunction

    ////////////////////////////////////////////////////////////
    // request
    ////////////////////////////////////////////////////////////

    assign req_adr = bus_log.adr;
    assign req_off = req_adr[OFF_W-1:0];
    assign req_msk = size_mask(bus_log.siz);
    assign log_wdt = bus_log.wdt;

    // rotate enables and write data up by the offset
    // lane index wraps modulo the lane count
    always_comb begin
        logic [OFF_W-1:0] idx;
        for (int unsigned i = 0; i < BYT; i++) begin
            idx = OFF_W'(i) - req_off;
            req_byt[i] = req_msk[idx];
            byt_wdt[i] = log_wdt[idx];
        end
    end

    // control passes straight through
    assign bus_byt.vld = bus_log.vld;
    assign bus_byt.wen = bus_log.wen;
    assign bus_byt.adr = bus_log.adr;
    assign bus_byt.siz = bus_log.siz;
    assign bus_byt.byt = req_byt;
    assign bus_byt.wdt = byt_wdt;

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    // alignment of the transfer being answered
    assign rsp_adr = bus_log.dly[TCB_DLY].adr;
    assign rsp_off = rsp_adr[OFF_W-1:0];
    assign rsp_msk = size_mask(bus_log.dly[TCB_DLY].siz);
    assign byt_rdt = bus_byt.rdt;

    // rotate down, then clear bytes above the size
    always_comb begin
        logic [OFF_W-1:0] idx;
        for (int unsigned i = 0; i < BYT; i++) begin
            idx = OFF_W'(i) + rsp_off;
            log_rdt[i] = rsp_msk[i] ? byt_rdt[idx] : '0;
        end
    end

    assign bus_log.rdt = log_rdt;
    assign bus_log.sts = bus_byt.sts;
    assign bus_log.rdy = bus_byt.rdy;

endmodule : tcb_lite_lib_logsize2byteena

`default_nettype wire

/* rtl/tcb_lite_lib_misaligned_memory_controller.sv */
`default_nettype none
`timescale 1ns/10ps

module tcb_lite_lib_misaligned_memory_controller
    import mem_pkg::*;
#(
    parameter int unsigned ADR_W = MEM_ADR_W_DEF,
    parameter int unsigned DAT_W = BUS_DAT_W_DEF,
    localparam int unsigned BYT     = DAT_W/8,
    localparam int unsigned OFF_W   = $clog2(BYT),
    localparam int unsigned MEM_ADR = ADR_W - OFF_W
)(
    tcb_lite_if.sub                    tcb,
    // per lane SRAM bank signals
    output logic  [BYT-1:0]              mem_cen,
    output logic  [BYT-1:0]              mem_wen,
    output logic  [BYT-1:0][MEM_ADR-1:0] mem_adr,
    output byte_t [BYT-1:0]              mem_wdt,
    input  byte_t [BYT-1:0]              mem_rdt
);

    // word address and the one after it
    logic [MEM_ADR-1:0] adr;
    logic [MEM_ADR-1:0] nxt;
    // byte offset inside the word
    logic [OFF_W-1:0]   off;

    ////////////////////////////////////////////////////////////
    // request
    ////////////////////////////////////////////////////////////

    // only enabled lanes of a valid request touch a bank
    assign mem_cen = {BYT{tcb.vld}} & tcb.byt;
    assign mem_wen = {BYT{tcb.wen}};

    assign adr = tcb.adr[OFF_W+:MEM_ADR];
    assign off = tcb.adr[OFF_W-1:0];
    // wraps to zero at the top of memory
    assign nxt = adr + 1'b1;

    // lanes below the offset belong to the next word
    for (genvar i = 0; i < BYT; i++) begin : g_adr
        assign mem_adr[i] = (OFF_W'(i) < off) ? nxt : adr;
    end

    // data already sits in its lane
    assign mem_wdt = tcb.wdt;

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    assign tcb.rdt = mem_rdt;
    assign tcb.sts = '0;
    // no back-pressure
    assign tcb.rdy = 1'b1;

endmodule : tcb_lite_lib_misaligned_memory_controller

`default_nettype wire

/* rtl/tcb_lite_pkg.sv */
`default_nettype none

package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////
    // transfer size
    ////////////////////////////////////////////////////////////

    // log2 of transfer size in bytes
    // only three sizes named, 2 bits leave room for a double word
    typedef enum logic [1:0] {
        TCB_SIZ_BYTE = 2'd0,
        TCB_SIZ_HALF = 2'd1,
        TCB_SIZ_WORD = 2'd2
    } tcb_siz_t;

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    // status, zero means success
    typedef logic tcb_sts_t;

    // read response latency in clock cycles
    // response phase samples the request this many cycles back
    localparam int unsigned TCB_DLY = 1;

endpackage : tcb_lite_pkg

`default_nettype wire

/* rtl/tcb_mem_top.sv */
`default_nettype none
`timescale 1ns/10ps

module tcb_mem_top
    import tcb_lite_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned ADR_W = MEM_ADR_W_DEF,
    parameter int unsigned DAT_W = BUS_DAT_W_DEF
)(
    input  logic             clk,
    input  logic             arst_n,
    // request
    input  logic             req_vld,
    input  logic             req_wen,
    input  logic [ADR_W-1:0] req_adr,
    input  tcb_siz_t         req_siz,
    input  logic [DAT_W-1:0] req_wdt,
    // response
    output logic             rsp_vld,
    output logic [DAT_W-1:0] rsp_rdt,
    output tcb_sts_t         rsp_sts
);

    localparam int unsigned BYT       = DAT_W/8;
    // bank depth, word address bits
    localparam int unsigned DEPTH_LOG = ADR_W - $clog2(BYT);

    // lane signals between controller and banks
    logic  [BYT-1:0]                mem_cen;
    logic  [BYT-1:0]                mem_wen;
    logic  [BYT-1:0][DEPTH_LOG-1:0] mem_adr;
    byte_t [BYT-1:0]                mem_wdt;
    byte_t [BYT-1:0]                mem_rdt;

    ////////////////////////////////////////////////////////////
    // buses
    ////////////////////////////////////////////////////////////

    // log-size side, from the ports
    tcb_lite_if #(.ADR_W(ADR_W), .DAT_W(DAT_W)) bus_log (.clk(clk), .arst_n(arst_n));
    // byte enable side, towards the banks
    tcb_lite_if #(.ADR_W(ADR_W), .DAT_W(DAT_W)) bus_byt (.clk(clk), .arst_n(arst_n));

    assign bus_log.vld = req_vld;
    assign bus_log.wen = req_wen;
    assign bus_log.adr = req_adr;
    assign bus_log.siz = req_siz;
    // enables are built by the converter
    assign bus_log.byt = '0;
    assign bus_log.wdt = req_wdt;

    // response only for reads
    assign rsp_vld = bus_log.dly[TCB_DLY].vld & ~bus_log.dly[TCB_DLY].wen;
    assign rsp_rdt = bus_log.rdt;
    assign rsp_sts = bus_log.sts;

    ////////////////////////////////////////////////////////////
    // converter, controller, banks
    ////////////////////////////////////////////////////////////

    tcb_lite_lib_logsize2byteena #(
        .ADR_W (ADR_W),
        .DAT_W (DAT_W)
    ) i_conv (
        .bus_log (bus_log),
        .bus_byt (bus_byt)
    );

    tcb_lite_lib_misaligned_memory_controller #(
        .ADR_W (ADR_W),
        .DAT_W (DAT_W)
    ) i_ctrl (
        .tcb     (bus_byt),
        .mem_cen (mem_cen),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt)
    );

    // one byte-wide bank per lane
    for (genvar i = 0; i < BYT; i++) begin : g_lane
        sram_bank #(
            .DEPTH_LOG (DEPTH_LOG)
        ) i_bank (
            .clk (clk),
            .cen (mem_cen[i]),
            .wen (mem_wen[i]),
            .adr (mem_adr[i]),
            .wdt (mem_wdt[i]),
            .rdt (mem_rdt[i])
        );
    end

endmodule : tcb_mem_top

`default_nettype wire

/* tests/tcb_mem_checker.sv */
`default_nettype none
`timescale 1ns/10ps

module tcb_mem_checker
    import tcb_lite_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned ADR_W = MEM_ADR_W_DEF,
    parameter int unsigned DAT_W = BUS_DAT_W_DEF
)(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             req_vld,
    input  logic             req_wen,
    input  logic [ADR_W-1:0] req_adr,
    input  tcb_siz_t         req_siz,
    input  logic [DAT_W-1:0] req_wdt,
    input  logic             rsp_vld,
    input  logic [DAT_W-1:0] rsp_rdt,
    input  tcb_sts_t         rsp_sts,
    input  logic             report_req,
    output int               errors
);

    localparam int unsigned BYT = DAT_W/8;

    // flat byte model, little endian
    byte_t            mem [0:2**ADR_W-1];
    // predictions waiting for their response
    logic [DAT_W-1:0] exp_q [$];
    logic [ADR_W-1:0] adr_q [$];
    // read accepted at the last edge
    logic             rd_last = 1'b0;
    int               vld_err = 0;
    int               rdt_err = 0;
    int               sts_err = 0;
    int               oth_err = 0;

    assign errors = vld_err + rdt_err + sts_err + oth_err;

    // bytes moved by one transfer, capped at the bus width
    function automatic int unsigned size_bytes(input tcb_siz_t siz);
        int unsigned n;
        n = 32'd1 << siz;
        return (n > BYT) ? BYT : n;
    endfunction

    ////////////////////////////////////////////////////////////
    // model update and prediction
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge arst_n) begin
        logic [DAT_W-1:0] exp;
        logic [ADR_W-1:0] a;
        if (!arst_n) begin
            rd_last <= 1'b0;
        end else begin
            rd_last <= req_vld && !req_wen;
            exp = '0;
            if (req_vld) begin
                // address plus k wraps at the top of memory
                for (int unsigned k = 0; k < size_bytes(req_siz); k++) begin
                    a = req_adr + ADR_W'(k);
                    if (req_wen) begin
                        mem[a] = req_wdt[8*k+:8];
                    end else begin
                        exp[8*k+:8] = mem[a];
                    end
                end
                if (!req_wen) begin
                    exp_q.push_back(exp);
                    adr_q.push_back(req_adr);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response compare, mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [DAT_W-1:0] exp;
        logic [ADR_W-1:0] a;
        // also covers reset and the first cycle after it
        if (rsp_vld !== rd_last) begin
            vld_err++;
            $display("ERROR %0t: rsp_vld is %b, expected %b", $time, rsp_vld, rd_last);
        end
        if (arst_n && rsp_sts !== 1'b0) begin
            sts_err++;
            $display("ERROR %0t: rsp_sts is %b, expected 0", $time, rsp_sts);
        end
        if (rd_last) begin
            if (exp_q.size() == 0) begin
                oth_err++;
                $display("a read response was due but no prediction was queued");
            end else begin
                exp = exp_q.pop_front();
                a   = adr_q.pop_front();
                if (rsp_rdt !== exp) begin
                    rdt_err++;
                    $display("ERROR %0t: read adr %h gave rsp_rdt %h, expected %h",
                             $time, a, rsp_rdt, exp);
                end
            end
        end
    end

    // closing count line
    always @(posedge report_req) begin
        if (exp_q.size() != 0) begin
            oth_err++;
            $display("%0d read responses never arrived", exp_q.size());
        end
        $display("error counts: rsp_vld %0d, rsp_rdt %0d, rsp_sts %0d, other %0d",
                 vld_err, rdt_err, sts_err, oth_err);
    end

endmodule : tcb_mem_checker

`default_nettype wire

/* tests/tcb_mem_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module tcb_mem_tb
    import tcb_lite_pkg::*;
    import mem_pkg::*;
();

    localparam int unsigned ADR_W   = MEM_ADR_W_DEF;
    localparam int unsigned DAT_W   = BUS_DAT_W_DEF;
    localparam int unsigned BYT     = DAT_W/8;
    localparam int unsigned WORDS   = (2**ADR_W)/BYT;
    localparam int unsigned PERIOD  = 100;
    localparam int unsigned DRV_DLY = 10;
    localparam int unsigned RST_CYC = 8;
    localparam int unsigned SEED    = 32'h9a08d19b;
    localparam int unsigned N_RAND  = 2000;
    // fill, readback, sweep of three sizes, wrap writes, random, final readback
    localparam int unsigned N_REQ   = 3*WORDS + 3*(2**ADR_W) + 4*(BYT-1) + N_RAND;
    localparam int unsigned MARGIN  = 200;
    localparam longint      WDOG_NS = longint'(N_REQ + RST_CYC + MARGIN) * PERIOD;

    logic             clk;
    logic             arst_n;
    logic             req_vld;
    logic             req_wen;
    logic [ADR_W-1:0] req_adr;
    tcb_siz_t         req_siz;
    logic [DAT_W-1:0] req_wdt;
    logic             rsp_vld;
    logic [DAT_W-1:0] rsp_rdt;
    tcb_sts_t         rsp_sts;
    logic             report_req;
    int               errors;

    ////////////////////////////////////////////////////////////
    // DUT and checker
    ////////////////////////////////////////////////////////////

    tcb_mem_top #(.ADR_W(ADR_W), .DAT_W(DAT_W)) i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_siz (req_siz),
        .req_wdt (req_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt),
        .rsp_sts (rsp_sts)
    );

    // watches the same ports, owns the memory model
    tcb_mem_checker #(.ADR_W(ADR_W), .DAT_W(DAT_W)) i_chk (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_vld    (req_vld),
        .req_wen    (req_wen),
        .req_adr    (req_adr),
        .req_siz    (req_siz),
        .req_wdt    (req_wdt),
        .rsp_vld    (rsp_vld),
        .rsp_rdt    (rsp_rdt),
        .rsp_sts    (rsp_sts),
        .report_req (report_req),
        .errors     (errors)
    );

    ////////////////////////////////////////////////////////////
    // clock and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD/2) clk = ~clk;
        end
    end

    initial begin
        #(WDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WDOG_NS);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // random bytes over the whole bus width
    function automatic logic [DAT_W-1:0] random_data();
        logic [DAT_W-1:0] d;
        for (int i = 0; i < int'(DAT_W); i += 8) begin
            d[i+:8] = 8'($urandom);
        end
        return d;
    endfunction

    // one request, accepted at the next rising edge
    task automatic send(input logic wen, input logic [ADR_W-1:0] adr,
                        input tcb_siz_t siz, input logic [DAT_W-1:0] wdt);
        @(posedge clk);
        #(DRV_DLY);
        req_vld = 1'b1;
        req_wen = wen;
        req_adr = adr;
        req_siz = siz;
        req_wdt = wdt;
    endtask

    task automatic idle();
        @(posedge clk);
        #(DRV_DLY);
        req_vld = 1'b0;
        req_wdt = random_data();
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n     = 1'b0;
        // a read held during reset must not be answered
        req_vld    = 1'b1;
        req_wen    = 1'b0;
        req_adr    = '0;
        req_siz    = TCB_SIZ_WORD;
        req_wdt    = '0;
        report_req = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        #(DRV_DLY);
        arst_n  = 1'b1;
        req_vld = 1'b0;
        // fill every word, then read it back
        for (int w = 0; w < int'(WORDS); w++) begin
            send(1'b1, ADR_W'(w*BYT), TCB_SIZ_WORD, random_data());
        end
        for (int w = 0; w < int'(WORDS); w++) begin
            send(1'b0, ADR_W'(w*BYT), TCB_SIZ_WORD, random_data());
        end
        // every offset and size, top address wraps
        for (int a = 0; a < 2**ADR_W; a++) begin
            for (int s = 0; s < 3; s++) begin
                send(1'b0, ADR_W'(a), tcb_siz_t'(2'(s)), random_data());
            end
        end
        // misaligned writes in the top word spill into word zero
        for (int a = 2**ADR_W - int'(BYT) + 1; a < 2**ADR_W; a++) begin
            for (int s = 1; s < 3; s++) begin
                send(1'b1, ADR_W'(a), tcb_siz_t'(2'(s)), random_data());
                send(1'b0, ADR_W'(a), TCB_SIZ_WORD, random_data());
            end
        end
        // mixed traffic with idle gaps
        for (int n = 0; n < int'(N_RAND); n++) begin
            if ($urandom % 4 == 0) begin
                idle();
            end else begin
                send(1'($urandom), ADR_W'($urandom), tcb_siz_t'(2'($urandom % 3)),
                     random_data());
            end
        end
        // neighbors of partial writes
        for (int w = 0; w < int'(WORDS); w++) begin
            send(1'b0, ADR_W'(w*BYT), TCB_SIZ_WORD, random_data());
        end
        repeat (3) idle();
        report_req = 1'b1;
        #1;
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tcb_mem_tb

`default_nettype wire
